// File: logic/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// Datapath widths
`define BWIDTH  32
`define DWIDTH  16
`define AWIDTH  40
`define LWIDTH  8

// Address bits of image buffer, weight memories and register file
`define MEMSIZE 10
`define NETSIZE 8
`define REGSIZE 4

`define WHICH_DENSE 1'b0
`define WHICH_CONV  1'b1

// Register map
`define REG_WHICH      4'h0
`define REG_REQ        4'h1
`define REG_QBITS      4'h2
`define REG_IN_OFFSET  4'h3
`define REG_OUT_OFFSET 4'h4
`define REG_NET_OFFSET 4'h5
`define REG_SHAPE      4'h6
`define REG_FLAGS      4'h7
`define REG_STATUS     4'h8

`endif

// File: logic/cnn_pkg.sv
`default_nettype none

`include "cnn_defines.svh"

package cnn_pkg;

  typedef logic [`MEMSIZE-1:0]       img_addr_t;
  typedef logic [`NETSIZE-1:0]       net_addr_t;
  typedef logic [`LWIDTH-1:0]        len_t;
  typedef logic signed [`DWIDTH-1:0] data_t;
  typedef logic signed [`AWIDTH-1:0] acc_t;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_RUN,
    CORE_BIAS,
    CORE_WRITE
  } core_state_t;

  typedef struct packed {
    len_t total_out;
    len_t total_in;
  } dense_shape_t;

  typedef struct packed {
    len_t conv_kern;
    len_t img_width;
  } conv_shape_t;

  // One shape word, meaning depends on the core that runs
  typedef union packed {
    dense_shape_t dense;
    conv_shape_t  conv;
  } shape_u;

  typedef struct packed {
    len_t      qbits;
    img_addr_t in_offset;
    img_addr_t out_offset;
    net_addr_t net_offset;
    shape_u    shape;
    logic      bias_en;
    logic      relu_en;
  } layer_cfg_t;

  typedef struct packed {
    logic      we;
    img_addr_t addr;
    data_t     wdata;
  } img_req_t;

  typedef struct packed {
    logic      we;
    logic      sel;
    net_addr_t addr;
    data_t     wdata;
  } net_wr_t;

  // Shift down, optional ReLU, keep the low word
  function automatic data_t quantize(
    input acc_t acc,
    input len_t qbits,
    input logic relu_en
  );
    acc_t shifted;
    shifted = acc >>> qbits;
    if (relu_en && shifted[`AWIDTH-1]) begin
      shifted = '0;
    end
    return shifted[`DWIDTH-1:0];
  endfunction

endpackage

`default_nettype wire

// File: logic/param_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module param_regs (
  input  logic                clk,
  input  logic                xrst,
  input  logic                reg_we,
  input  logic                reg_re,
  input  logic [`REGSIZE-1:0] reg_addr,
  input  logic [`BWIDTH-1:0]  reg_wdata,
  input  logic                dense_done,
  input  logic                conv_done,
  output logic [`BWIDTH-1:0]  reg_rdata,
  output cnn_pkg::layer_cfg_t cfg,
  output logic                dense_start,
  output logic                conv_start,
  output logic                which_run
);

  logic               which;
  logic               ack;
  logic               req_wr;
  logic [`BWIDTH-1:0] rd_word;

  assign req_wr = reg_we && reg_addr == `REG_REQ && reg_wdata[0];

  // ==============================
  // Layer registers
  always_ff @(posedge clk) begin
    if (!xrst) begin
      which <= `WHICH_DENSE;
      cfg   <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        `REG_WHICH:      which          <= reg_wdata[0];
        `REG_QBITS:      cfg.qbits      <= reg_wdata[`LWIDTH-1:0];
        `REG_IN_OFFSET:  cfg.in_offset  <= reg_wdata[`MEMSIZE-1:0];
        `REG_OUT_OFFSET: cfg.out_offset <= reg_wdata[`MEMSIZE-1:0];
        `REG_NET_OFFSET: cfg.net_offset <= reg_wdata[`NETSIZE-1:0];
        `REG_SHAPE:      cfg.shape      <= reg_wdata[2*`LWIDTH-1:0];
        `REG_FLAGS: begin
          cfg.bias_en <= reg_wdata[0];
          cfg.relu_en <= reg_wdata[1];
        end
        default: ;
      endcase
    end
  end

  // ==============================
  // Start pulse and ack
  always_ff @(posedge clk) begin
    if (!xrst) begin
      dense_start <= 1'b0;
      conv_start  <= 1'b0;
      which_run   <= `WHICH_DENSE;
      ack         <= 1'b0;
    end else begin
      dense_start <= req_wr && which == `WHICH_DENSE;
      conv_start  <= req_wr && which == `WHICH_CONV;
      if (req_wr) begin
        which_run <= which;
        ack       <= 1'b0;
      end else if (dense_done || conv_done) begin
        ack <= 1'b1;
      end
    end
  end

  // REG_REQ reads as zero
  always_comb begin
    rd_word = '0;
    case (reg_addr)
      `REG_WHICH:      rd_word[0] = which;
      `REG_QBITS:      rd_word[`LWIDTH-1:0] = cfg.qbits;
      `REG_IN_OFFSET:  rd_word[`MEMSIZE-1:0] = cfg.in_offset;
      `REG_OUT_OFFSET: rd_word[`MEMSIZE-1:0] = cfg.out_offset;
      `REG_NET_OFFSET: rd_word[`NETSIZE-1:0] = cfg.net_offset;
      `REG_SHAPE:      rd_word[2*`LWIDTH-1:0] = cfg.shape;
      `REG_FLAGS:      rd_word[1:0] = {cfg.relu_en, cfg.bias_en};
      `REG_STATUS:     rd_word[1:0] = {which_run, ack};
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rdata <= '0;
    end else if (reg_re) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: logic/image_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module image_buffer (
  input  logic              clk,
  input  logic              which_run,
  input  logic              dense_busy,
  input  logic              conv_busy,
  input  cnn_pkg::img_req_t host_req,
  input  cnn_pkg::img_req_t dense_req,
  input  cnn_pkg::img_req_t conv_req,
  output cnn_pkg::data_t    img_rdata
);

  import cnn_pkg::*;

  data_t    mem [2**`MEMSIZE];
  img_req_t sel;

  // Running core owns the memory, host gets it otherwise
  always_comb begin
    if (which_run == `WHICH_DENSE && dense_busy) begin
      sel = dense_req;
    end else if (which_run == `WHICH_CONV && conv_busy) begin
      sel = conv_req;
    end else begin
      sel = host_req;
    end
  end

  // ==============================
  // Single port array, read data shared by all requesters
  always_ff @(posedge clk) begin
    if (sel.we) begin
      mem[sel.addr] <= sel.wdata;
    end
    img_rdata <= mem[sel.addr];
  end

endmodule

`default_nettype wire

// File: logic/dense_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module dense_core (
  input  logic                clk,
  input  logic                xrst,
  input  logic                start,
  input  cnn_pkg::layer_cfg_t cfg,
  input  cnn_pkg::net_wr_t    net_wr,
  input  cnn_pkg::data_t      img_rdata,
  output cnn_pkg::img_req_t   img_req,
  output logic                busy,
  output logic                done
);

  import cnn_pkg::*;

  layer_cfg_t  lc;
  core_state_t state;
  len_t        o;
  len_t        i;
  logic        mac_v;
  logic        last_in;
  logic        last_out;
  acc_t        acc;
  acc_t        bias;
  data_t       wmem [2**`NETSIZE];
  data_t       w_rdata;
  net_addr_t   w_addr;

  assign last_in  = i == lc.shape.dense.total_in - len_t'(1);
  assign last_out = o == lc.shape.dense.total_out - len_t'(1);
  assign bias     = acc_t'(w_rdata);
  assign busy     = state != CORE_IDLE;
  assign done     = state == CORE_WRITE && last_out;

  // Row o of the weight block, bias words follow the whole matrix
  always_comb begin
    if (state == CORE_RUN) begin
      w_addr = lc.net_offset + net_addr_t'(o) * net_addr_t'(lc.shape.dense.total_in)
             + net_addr_t'(i);
    end else begin
      w_addr = lc.net_offset
             + net_addr_t'(lc.shape.dense.total_out) * net_addr_t'(lc.shape.dense.total_in)
             + net_addr_t'(o);
    end
  end

  always_comb begin
    img_req.we    = state == CORE_WRITE;
    img_req.wdata = quantize(acc + (lc.bias_en ? bias : '0), lc.qbits, lc.relu_en);
    if (state == CORE_RUN) begin
      img_req.addr = lc.in_offset + img_addr_t'(i);
    end else begin
      img_req.addr = lc.out_offset + img_addr_t'(o);
    end
  end

  always_ff @(posedge clk) begin
    if (net_wr.we && net_wr.sel == `WHICH_DENSE) begin
      wmem[net_wr.addr] <= net_wr.wdata;
    end
    w_rdata <= wmem[w_addr];
    if (start) begin
      lc <= cfg;
    end
  end

  // ==============================
  // Sequencer, products land one cycle after issue
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= CORE_IDLE;
      o     <= '0;
      i     <= '0;
      mac_v <= 1'b0;
      acc   <= '0;
    end else begin
      mac_v <= state == CORE_RUN;
      case (state)
        CORE_IDLE: begin
          if (start) begin
            state <= CORE_RUN;
            o     <= '0;
            i     <= '0;
            acc   <= '0;
          end
        end
        CORE_RUN: begin
          i <= i + len_t'(1);
          if (last_in) begin
            i     <= '0;
            state <= CORE_BIAS;
          end
        end
        CORE_BIAS: state <= CORE_WRITE;
        CORE_WRITE: begin
          acc   <= '0;
          o     <= o + len_t'(1);
          state <= last_out ? CORE_IDLE : CORE_RUN;
        end
      endcase
      if (mac_v) begin
        acc <= acc + acc_t'(img_rdata) * acc_t'(w_rdata);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/conv1d_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module conv1d_core (
  input  logic                clk,
  input  logic                xrst,
  input  logic                start,
  input  cnn_pkg::layer_cfg_t cfg,
  input  cnn_pkg::net_wr_t    net_wr,
  input  cnn_pkg::data_t      img_rdata,
  output cnn_pkg::img_req_t   img_req,
  output logic                busy,
  output logic                done
);

  import cnn_pkg::*;

  layer_cfg_t  lc;
  core_state_t state;
  len_t        j;
  len_t        k;
  logic        mac_v;
  logic        last_in;
  logic        last_out;
  acc_t        acc;
  acc_t        bias;
  data_t       wmem [2**`NETSIZE];
  data_t       w_rdata;
  net_addr_t   w_addr;

  // Valid positions only, stride 1 and no padding
  assign last_in  = k == lc.shape.conv.conv_kern - len_t'(1);
  assign last_out = j == lc.shape.conv.img_width - lc.shape.conv.conv_kern;
  assign bias     = acc_t'(w_rdata);
  assign busy     = state != CORE_IDLE;
  assign done     = state == CORE_WRITE && last_out;

  // Kernel taps then the bias word
  always_comb begin
    if (state == CORE_RUN) begin
      w_addr = lc.net_offset + net_addr_t'(k);
    end else begin
      w_addr = lc.net_offset + net_addr_t'(lc.shape.conv.conv_kern);
    end
  end

  always_comb begin
    img_req.we    = state == CORE_WRITE;
    img_req.wdata = quantize(acc + (lc.bias_en ? bias : '0), lc.qbits, lc.relu_en);
    if (state == CORE_RUN) begin
      img_req.addr = lc.in_offset + img_addr_t'(j) + img_addr_t'(k);
    end else begin
      img_req.addr = lc.out_offset + img_addr_t'(j);
    end
  end

  always_ff @(posedge clk) begin
    if (net_wr.we && net_wr.sel == `WHICH_CONV) begin
      wmem[net_wr.addr] <= net_wr.wdata;
    end
    w_rdata <= wmem[w_addr];
    if (start) begin
      lc <= cfg;
    end
  end

  // ==============================
  // Sequencer
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= CORE_IDLE;
      j     <= '0;
      k     <= '0;
      mac_v <= 1'b0;
      acc   <= '0;
    end else begin
      mac_v <= state == CORE_RUN;
      case (state)
        CORE_IDLE: begin
          if (start) begin
            state <= CORE_RUN;
            j     <= '0;
            k     <= '0;
            acc   <= '0;
          end
        end
        CORE_RUN: begin
          k <= k + len_t'(1);
          if (last_in) begin
            k     <= '0;
            state <= CORE_BIAS;
          end
        end
        CORE_BIAS: state <= CORE_WRITE;
        CORE_WRITE: begin
          acc   <= '0;
          j     <= j + len_t'(1);
          state <= last_out ? CORE_IDLE : CORE_RUN;
        end
      endcase
      if (mac_v) begin
        acc <= acc + acc_t'(img_rdata) * acc_t'(w_rdata);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cnn_accel_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_accel_top (
  input  logic                clk,
  input  logic                xrst,
  input  logic                reg_we,
  input  logic                reg_re,
  input  logic [`REGSIZE-1:0] reg_addr,
  input  logic [`BWIDTH-1:0]  reg_wdata,
  input  cnn_pkg::net_wr_t    net_wr,
  input  cnn_pkg::img_req_t   host_img,
  output logic [`BWIDTH-1:0]  reg_rdata,
  output cnn_pkg::data_t      img_rdata
);

  import cnn_pkg::*;

  layer_cfg_t cfg;
  logic       which_run;
  logic       dense_start;
  logic       dense_busy;
  logic       dense_done;
  logic       conv_start;
  logic       conv_busy;
  logic       conv_done;
  img_req_t   dense_req;
  img_req_t   conv_req;

  param_regs u_param_regs (
    .clk         (clk),
    .xrst        (xrst),
    .reg_we      (reg_we),
    .reg_re      (reg_re),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .dense_done  (dense_done),
    .conv_done   (conv_done),
    .reg_rdata   (reg_rdata),
    .cfg         (cfg),
    .dense_start (dense_start),
    .conv_start  (conv_start),
    .which_run   (which_run)
  );

  image_buffer u_image_buffer (
    .clk        (clk),
    .which_run  (which_run),
    .dense_busy (dense_busy),
    .conv_busy  (conv_busy),
    .host_req   (host_img),
    .dense_req  (dense_req),
    .conv_req   (conv_req),
    .img_rdata  (img_rdata)
  );

  // ==============================
  // Compute cores
  dense_core u_dense_core (
    .clk       (clk),
    .xrst      (xrst),
    .start     (dense_start),
    .cfg       (cfg),
    .net_wr    (net_wr),
    .img_rdata (img_rdata),
    .img_req   (dense_req),
    .busy      (dense_busy),
    .done      (dense_done)
  );

  conv1d_core u_conv1d_core (
    .clk       (clk),
    .xrst      (xrst),
    .start     (conv_start),
    .cfg       (cfg),
    .net_wr    (net_wr),
    .img_rdata (img_rdata),
    .img_req   (conv_req),
    .busy      (conv_busy),
    .done      (conv_done)
  );

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tests/cnn_accel_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_accel_tb;

  import cnn_pkg::*;

  localparam int NET_OFF   = 4;
  localparam int D_IN_OFF  = 'h10;
  localparam int D_OUT_OFF = 'h40;
  localparam int D_OUTS    = 3;
  localparam int D_INS     = 5;
  localparam int C_IN_OFF  = 'h80;
  localparam int C_OUT_OFF = 'hc0;
  localparam int C_WIDTH   = 8;
  localparam int C_KERN    = 3;
  localparam int ACK_POLLS = 200;

  logic                clk;
  logic                xrst;
  logic                reg_we;
  logic                reg_re;
  logic [`REGSIZE-1:0] reg_addr;
  logic [`BWIDTH-1:0]  reg_wdata;
  logic [`BWIDTH-1:0]  reg_rdata;
  net_wr_t             net_wr;
  img_req_t            host_img;
  data_t               img_rdata;

  logic [31:0]         rng_state;
  int                  mismatch_cnt;
  int                  timeout_cnt;
  logic signed [15:0]  img_model [2**`MEMSIZE];
  logic signed [15:0]  dense_w [2**`NETSIZE];
  logic signed [15:0]  conv_w [2**`NETSIZE];
  int                  addr_list [16];
  logic [31:0]         rd;
  logic [31:0]         r;
  logic signed [15:0]  got;

  tb_clkgen u_tb_clkgen (
    .clk (clk)
  );

  cnn_accel_top u_cnn_accel_top (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_re    (reg_re),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .net_wr    (net_wr),
    .host_img  (host_img),
    .reg_rdata (reg_rdata),
    .img_rdata (img_rdata)
  );

  // ==============================
  // Random values and checking
  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Range -8..7 keeps the sums small
  function logic signed [15:0] small_val();
    logic [31:0] v;
    v = next_rand();
    return {{12{v[19]}}, v[19:16]};
  endfunction

  function logic signed [15:0] neg_val();
    logic [31:0]        v;
    logic signed [15:0] m;
    v = next_rand();
    m = {13'd0, v[18:16]};
    return -m - 16'sd1;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s: expected %0h actual %0h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  // ==============================
  // Bus tasks
  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_we = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    reg_re   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    #1;
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic reg_check(input logic [3:0] addr, input logic [31:0] val);
    logic [31:0] v;
    reg_write(addr, val);
    reg_read(addr, v);
    expect_equal($sformatf("reg_readback_%0d", addr), val, v);
  endtask

  task automatic img_write(input int addr, input logic signed [15:0] data);
    @(posedge clk);
    #1;
    host_img.we    = 1'b1;
    host_img.addr  = addr[`MEMSIZE-1:0];
    host_img.wdata = data;
    img_model[addr] = data;
    @(posedge clk);
    #1;
    host_img.we = 1'b0;
  endtask

  task automatic img_read(input int addr, output logic signed [15:0] data);
    @(posedge clk);
    #1;
    host_img.we   = 1'b0;
    host_img.addr = addr[`MEMSIZE-1:0];
    @(posedge clk);
    #1;
    data = img_rdata;
  endtask

  task automatic net_write(input logic sel, input int addr, input logic signed [15:0] data);
    @(posedge clk);
    #1;
    net_wr.we    = 1'b1;
    net_wr.sel   = sel;
    net_wr.addr  = addr[`NETSIZE-1:0];
    net_wr.wdata = data;
    if (sel == `WHICH_DENSE) begin
      dense_w[addr] = data;
    end else begin
      conv_w[addr] = data;
    end
    @(posedge clk);
    #1;
    net_wr.we = 1'b0;
  endtask

  task automatic program_layer(input logic which, input int qbits, input int in_off,
                               input int out_off, input logic [15:0] shape,
                               input logic [1:0] flags);
    reg_write(`REG_WHICH, {31'd0, which});
    reg_write(`REG_QBITS, qbits);
    reg_write(`REG_IN_OFFSET, in_off);
    reg_write(`REG_OUT_OFFSET, out_off);
    reg_write(`REG_NET_OFFSET, NET_OFF);
    reg_write(`REG_SHAPE, {16'd0, shape});
    reg_write(`REG_FLAGS, {30'd0, flags});
  endtask

  task automatic wait_ack(input string name);
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = '0;
    while (!st[0] && polls < ACK_POLLS) begin
      reg_read(`REG_STATUS, st);
      polls++;
    end
    if (!st[0]) begin
      $display("Timeout: ack never came back during the %s layer", name);
      timeout_cnt++;
    end
  endtask

  task automatic compare_region(input string name, input int base, input int n);
    logic signed [15:0] v;
    for (int a = 0; a < n; a++) begin
      img_read(base + a, v);
      expect_equal($sformatf("%s[%0d]", name, a), 32'(img_model[base + a]), 32'(v));
    end
  endtask

  // ==============================
  // Reference model
  function logic signed [15:0] scale_result(input longint acc, input int qbits,
                                            input bit relu_en);
    longint s;
    s = acc >>> qbits;
    if (relu_en && s < 0) begin
      s = 0;
    end
    return s[15:0];
  endfunction

  // Bias on, ReLU on, shift by 2
  task automatic dense_model();
    longint acc;
    for (int o = 0; o < D_OUTS; o++) begin
      acc = 0;
      for (int i = 0; i < D_INS; i++) begin
        acc += longint'(img_model[D_IN_OFF + i]) * longint'(dense_w[NET_OFF + o * D_INS + i]);
      end
      acc += longint'(dense_w[NET_OFF + D_OUTS * D_INS + o]);
      img_model[D_OUT_OFF + o] = scale_result(acc, 2, 1'b1);
    end
  endtask

  // No bias, no ReLU, shift by 1
  task automatic conv_model();
    longint acc;
    for (int j = 0; j <= C_WIDTH - C_KERN; j++) begin
      acc = 0;
      for (int k = 0; k < C_KERN; k++) begin
        acc += longint'(img_model[C_IN_OFF + j + k]) * longint'(conv_w[NET_OFF + k]);
      end
      img_model[C_OUT_OFF + j] = scale_result(acc, 1, 1'b0);
    end
  endtask

  // ==============================
  // Test sequence
  initial begin
    rng_state    = 32'h464a_5c84;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    xrst         = 1'b0;
    reg_we       = 1'b0;
    reg_re       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    net_wr       = '0;
    host_img     = '0;
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;

    reg_read(`REG_STATUS, rd);
    expect_equal("status_after_reset", 32'h0, rd);
    reg_check(`REG_WHICH, 32'h1);
    reg_check(`REG_QBITS, 32'h5a);
    reg_check(`REG_IN_OFFSET, 32'h2a5);
    reg_check(`REG_OUT_OFFSET, 32'h15a);
    reg_check(`REG_NET_OFFSET, 32'hc3);
    reg_check(`REG_SHAPE, 32'h9c36);
    reg_check(`REG_FLAGS, 32'h2);

    // Host image path
    for (int n = 0; n < 16; n++) begin
      r = next_rand();
      addr_list[n] = int'(r[`MEMSIZE-1:0]);
      img_write(addr_list[n], $signed(r[31:16]));
    end
    for (int n = 0; n < 16; n++) begin
      img_read(addr_list[n], got);
      expect_equal("img_readback", 32'(img_model[addr_list[n]]), 32'(got));
    end

    // Dense layer
    for (int i = 0; i < D_INS; i++) begin
      img_write(D_IN_OFF + i, small_val());
    end
    for (int w = 0; w < D_OUTS * D_INS + D_OUTS; w++) begin
      net_write(`WHICH_DENSE, NET_OFF + w, small_val());
    end
    program_layer(`WHICH_DENSE, 2, D_IN_OFF, D_OUT_OFF, {8'(D_OUTS), 8'(D_INS)}, 2'b11);
    reg_write(`REG_REQ, 32'h1);
    wait_ack("dense");
    dense_model();
    compare_region("dense_out", D_OUT_OFF, D_OUTS);

    // Conv layer, weights share addresses with the dense ones
    for (int i = 0; i < C_WIDTH; i++) begin
      img_write(C_IN_OFF + i, small_val());
    end
    for (int k = 0; k < C_KERN; k++) begin
      net_write(`WHICH_CONV, NET_OFF + k, neg_val());
    end
    program_layer(`WHICH_CONV, 1, C_IN_OFF, C_OUT_OFF, {8'(C_KERN), 8'(C_WIDTH)}, 2'b00);
    reg_write(`REG_REQ, 32'h1);
    wait_ack("conv");
    conv_model();
    compare_region("conv_out", C_OUT_OFF, C_WIDTH - C_KERN + 1);
    compare_region("dense_kept", D_OUT_OFF, D_OUTS);
    reg_read(`REG_STATUS, rd);
    expect_equal("status_conv_done", 32'h3, rd);

    // New request clears ack
    program_layer(`WHICH_DENSE, 2, D_IN_OFF, D_OUT_OFF, {8'(D_OUTS), 8'(D_INS)}, 2'b11);
    reg_write(`REG_REQ, 32'h1);
    reg_read(`REG_STATUS, rd);
    expect_equal("status_ack_cleared", 32'h0, rd);
    wait_ack("dense_rerun");
    reg_read(`REG_STATUS, rd);
    expect_equal("status_dense_done", 32'h1, rd);
    compare_region("dense_rerun", D_OUT_OFF, D_OUTS);

    // Conv weight writes leave the dense result alone
    for (int k = 0; k < C_KERN; k++) begin
      net_write(`WHICH_CONV, NET_OFF + k, neg_val());
    end
    reg_write(`REG_REQ, 32'h1);
    wait_ack("dense_after_conv_load");
    dense_model();
    compare_region("dense_isolated", D_OUT_OFF, D_OUTS);
    program_layer(`WHICH_CONV, 1, C_IN_OFF, C_OUT_OFF, {8'(C_KERN), 8'(C_WIDTH)}, 2'b00);
    reg_write(`REG_REQ, 32'h1);
    wait_ack("conv_new_weights");
    conv_model();
    compare_region("conv_new", C_OUT_OFF, C_WIDTH - C_KERN + 1);

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/cnn_pkg.sv
logic/param_regs.sv
logic/image_buffer.sv
logic/dense_core.sv
logic/conv1d_core.sv
logic/cnn_accel_top.sv
tests/tb_clkgen.sv
tests/cnn_accel_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cnn_accel_tb -f sources.f -o sim_cnn_accel
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/sim_cnn_accel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "run.sh: simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
echo "run.sh: pass line not found in sim.log"
exit 1
